/* qerv.f */
+incdir+include
verilog/qerv_pkg.sv
verilog/qerv_state.sv
verilog/qerv_decode.sv
verilog/qerv_immdec.sv
verilog/qerv_alu.sv
verilog/qerv_rf_if.sv
verilog/qerv_ctrl.sv
verilog/qerv_top.sv
verification/tb_qerv.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the qerv testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_qerv -f qerv.f -Mdir obj_dir

output="$(./obj_dir/Vtb_qerv)"
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
   exit 0
fi
exit 1

/* include/tb_qerv_ref.svh */
`ifndef TB_QERV_REF_SVH
`define TB_QERV_REF_SVH

// Decode of the supported subset, mirrors the ISA tables
task automatic ref_decode(input logic [31:0] insn, output qerv_pkg::alu_op_e op,
                          output logic use_imm, output logic writes);
   logic [2:0] f3;
   logic [6:0] f7;
   logic       r_type;
   f3 = insn[14:12];
   f7 = insn[31:25];
   r_type = (insn[6:0] == qerv_pkg::OPC_OP);
   use_imm = (insn[6:0] == qerv_pkg::OPC_OP_IMM);
   op = qerv_pkg::ALU_NONE;
   if (use_imm || (r_type && f7 == qerv_pkg::F7_BASE)) begin
      case (f3)
         qerv_pkg::F3_ADD_SUB: op = qerv_pkg::ALU_ADD;
         qerv_pkg::F3_XOR: op = qerv_pkg::ALU_XOR;
         qerv_pkg::F3_OR: op = qerv_pkg::ALU_OR;
         qerv_pkg::F3_AND: op = qerv_pkg::ALU_AND;
         default: op = qerv_pkg::ALU_NONE;
      endcase
   end else if (r_type && f7 == qerv_pkg::F7_SUB && f3 == qerv_pkg::F3_ADD_SUB) begin
      op = qerv_pkg::ALU_SUB;
   end
   writes = (op != qerv_pkg::ALU_NONE) && (insn[11:7] != 5'd0);
endtask

// Expected rd value with 32-bit wraparound
function automatic logic [31:0] ref_result(input qerv_pkg::alu_op_e op,
                                           input logic [31:0] rs1, input logic [31:0] rs2,
                                           input logic [11:0] imm, input logic use_imm);
   logic [31:0] b;
   b = use_imm ? {{20{imm[11]}}, imm} : rs2;
   case (op)
      qerv_pkg::ALU_ADD: return rs1 + b;
      qerv_pkg::ALU_SUB: return rs1 - b;
      qerv_pkg::ALU_AND: return rs1 & b;
      qerv_pkg::ALU_OR: return rs1 | b;
      qerv_pkg::ALU_XOR: return rs1 ^ b;
      default: return 32'h0;
   endcase
endfunction

// Register file model, one nibble per cycle
task automatic rf_get_nibble(input logic [31:0] val, input int k, output logic [3:0] nib);
   nib = val[k*4 +: 4];
endtask

task automatic rf_put_nibble(inout logic [31:0] acc, input logic [3:0] nib);
   acc = {nib, acc[31:4]};
endtask

`endif

/* verification/tb_qerv.sv */
`timescale 1ns/100ps

module tb_qerv;
   import qerv_pkg::*;

   `include "tb_qerv_ref.svh"

   localparam int NUM_INSN = 200;
   localparam int RESET_CYCLES = 5;
   // Worst case per instruction stays well under 30 cycles
   localparam int WATCHDOG_NS = NUM_INSN * 30 * 10;

   typedef struct packed {
      logic [31:0] insn;
      logic [31:0] a;
      logic [31:0] b;
      logic [3:0]  wen_cnt;
      logic [4:0]  wreg;
      logic [31:0] data;
   } run_rec_t;

   logic        clk;
   logic        i_rst;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        o_rf_rreq;
   logic        i_rf_ready;
   logic [4:0]  o_rreg0;
   logic [4:0]  o_rreg1;
   logic [3:0]  i_rdata0;
   logic [3:0]  i_rdata1;
   logic        o_wen0;
   logic [4:0]  o_wreg0;
   logic [3:0]  o_wdata0;

   int          seed;
   logic [31:0] insns [NUM_INSN];
   int          ack_dly [NUM_INSN];
   int          rdy_dly [NUM_INSN];
   logic [31:0] reg_init [32];
   logic [31:0] regs [32];
   run_rec_t    runs [$];
   int          checked = 0;
   int          fetch_errs = 0;
   int          rreg_errs = 0;
   int          result_errs = 0;
   int          reset_errs = 0;

   qerv_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Random program, stall lengths and register contents
   task automatic build_stimulus();
      int          n;
      logic [31:0] r;
      logic [31:0] f;
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic [6:0]  f7;
      seed = 32'h3e591bfb;
      for (n = 0; n < NUM_INSN; n++) begin
         r = $random(seed);
         f = $random(seed);
         rd = (r[31:29] == 3'd0) ? 5'd0 : r[12:8];
         // RV32I funct3 of ADD, AND, OR, XOR
         case (r[5:4])
            2'd0: f3 = 3'b000;
            2'd1: f3 = 3'b111;
            2'd2: f3 = 3'b110;
            default: f3 = 3'b100;
         endcase
         if (r[2:0] == 3'd0) begin
            // Load, store, madd or branch opcode
            insns[n] = {f[31:12], rd, r[7:6], 5'b00011};
         end else if (r[2:0] < 3'd5) begin
            f7 = (f3 == 3'b000 && r[6]) ? 7'b0100000 : 7'b0000000;
            insns[n] = {f7, f[24:20], f[19:15], f3, rd, 7'b0110011};
         end else begin
            insns[n] = {f[31:20], f[19:15], f3, rd, 7'b0010011};
         end
         ack_dly[n] = int'(r[15:14]);
         rdy_dly[n] = int'(r[17:16]) + 1;
      end
      for (n = 0; n < 32; n++) begin
         reg_init[n] = (n == 0) ? 32'h0 : $random(seed);
      end
   endtask

   initial begin : main
      i_rst = 1'b1;
      build_stimulus();
      repeat (RESET_CYCLES) @(posedge clk);
      i_rst <= 1'b0;
      @(negedge clk);
      assert (!o_ibus_cyc && !o_rf_rreq && !o_wen0) else begin
         reset_errs++;
         $display("[ERROR] %0t: outputs active in reset, cyc=%b rreq=%b wen=%b",
                  $time, o_ibus_cyc, o_rf_rreq, o_wen0);
      end
      wait (checked == NUM_INSN);
      @(posedge clk);
      $display("Error counts: reset %0d, fetch %0d, rreg %0d, result %0d over %0d instructions",
               reset_errs, fetch_errs, rreg_errs, result_errs, checked);
      if (reset_errs + fetch_errs + rreg_errs + result_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Instruction bus, answers each fetch after a random stall
   initial begin : ibus_model
      int          n;
      int          d;
      logic [31:0] exp_pc;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      // Reset vector is address zero
      exp_pc = 32'h0000_0000;
      @(negedge i_rst);
      for (n = 0; n < NUM_INSN; n++) begin
         @(posedge clk);
         while (!o_ibus_cyc) @(posedge clk);
         for (d = 0; d <= ack_dly[n]; d++) begin
            if (d > 0) @(posedge clk);
            assert (o_ibus_cyc && o_ibus_adr == exp_pc) else begin
               fetch_errs++;
               $display("[ERROR] %0t: fetch %0d expected cyc=1 adr %h, got cyc=%b adr %h",
                        $time, n, exp_pc, o_ibus_cyc, o_ibus_adr);
            end
         end
         i_ibus_ack <= 1'b1;
         i_ibus_rdt <= insns[n];
         @(posedge clk);
         i_ibus_ack <= 1'b0;
         exp_pc = exp_pc + 32'd4;
      end
   end

   // Register file, serves the read nibbles and collects the written ones
   initial begin : rf_model
      int          n;
      int          k;
      run_rec_t    rec;
      logic [3:0]  nib0;
      logic [3:0]  nib1;
      logic [31:0] acc;
      i_rf_ready = 1'b0;
      i_rdata0 = '0;
      i_rdata1 = '0;
      @(negedge i_rst);
      regs = reg_init;
      for (n = 0; n < NUM_INSN; n++) begin
         @(posedge clk);
         while (!o_rf_rreq) @(posedge clk);
         assert (o_rreg0 == insns[n][19:15] &&
                 (insns[n][6:0] != 7'b0110011 || o_rreg1 == insns[n][24:20])) else begin
            rreg_errs++;
            $display("[ERROR] %0t: insn %h expected rreg0 %0d rreg1 %0d, got %0d %0d",
                     $time, insns[n], insns[n][19:15], insns[n][24:20], o_rreg0, o_rreg1);
         end
         rec = '0;
         rec.insn = insns[n];
         rec.a = regs[o_rreg0];
         rec.b = regs[o_rreg1];
         repeat (rdy_dly[n] - 1) @(posedge clk);
         i_rf_ready <= 1'b1;
         @(posedge clk);
         i_rf_ready <= 1'b0;
         acc = '0;
         for (k = 0; k < 8; k++) begin
            rf_get_nibble(rec.a, k, nib0);
            rf_get_nibble(rec.b, k, nib1);
            i_rdata0 <= nib0;
            i_rdata1 <= nib1;
            @(posedge clk);
            rf_put_nibble(acc, o_wdata0);
            if (o_wen0) begin
               rec.wen_cnt = rec.wen_cnt + 4'd1;
               rec.wreg = o_wreg0;
            end
         end
         rec.data = acc;
         if (rec.wen_cnt == 4'd8 && rec.wreg != 5'd0) begin
            regs[rec.wreg] = acc;
         end
         runs.push_back(rec);
      end
   end

   always @(negedge clk) begin : compare
      run_rec_t    rec;
      alu_op_e     op;
      logic        use_imm;
      logic        writes;
      logic [31:0] exp_val;
      if (checked < runs.size()) begin
         rec = runs[checked];
         ref_decode(rec.insn, op, use_imm, writes);
         exp_val = ref_result(op, rec.a, rec.b, rec.insn[31:20], use_imm);
         if (writes) begin
            assert (rec.wen_cnt == 4'd8 && rec.wreg == rec.insn[11:7] && rec.data == exp_val)
            else begin
               result_errs++;
               $display("[ERROR] %0t: insn %h expected x%0d = %h, got %0d writes to x%0d = %h",
                        $time, rec.insn, rec.insn[11:7], exp_val, rec.wen_cnt, rec.wreg,
                        rec.data);
            end
         end else begin
            assert (rec.wen_cnt == 4'd0) else begin
               result_errs++;
               $display("[ERROR] %0t: insn %h expected no write, got %0d write cycles",
                        $time, rec.insn, rec.wen_cnt);
            end
         end
         checked++;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: run did not finish within %0d ns, %0d of %0d instructions checked",
               WATCHDOG_NS, checked, NUM_INSN);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* verilog/qerv_top.sv */
`timescale 1ns/100ps

module qerv_top (
   input  logic                          clk,
   input  logic                          i_rst,
   output logic [qerv_pkg::XLEN-1:0]     o_ibus_adr,
   output logic                          o_ibus_cyc,
   input  logic [qerv_pkg::XLEN-1:0]     i_ibus_rdt,
   input  logic                          i_ibus_ack,
   output logic                          o_rf_rreq,
   input  logic                          i_rf_ready,
   output logic [qerv_pkg::REG_AW-1:0]   o_rreg0,
   output logic [qerv_pkg::REG_AW-1:0]   o_rreg1,
   input  logic [qerv_pkg::NIB_W-1:0]    i_rdata0,
   input  logic [qerv_pkg::NIB_W-1:0]    i_rdata1,
   output logic                          o_wen0,
   output logic [qerv_pkg::REG_AW-1:0]   o_wreg0,
   output logic [qerv_pkg::NIB_W-1:0]    o_wdata0
);
   import qerv_pkg::*;

   logic              cnt_en;
   logic              cnt_first;
   alu_op_e           alu_op;
   logic              op_b_imm;
   logic              rd_write;
   logic [REG_AW-1:0] rd_addr;
   logic [REG_AW-1:0] rs1_addr;
   logic [REG_AW-1:0] rs2_addr;
   logic [NIB_W-1:0]  imm;
   logic [NIB_W-1:0]  rs1;
   logic [NIB_W-1:0]  rs2;
   logic [NIB_W-1:0]  alu_rd;

   qerv_state state (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_ibus_ack  (i_ibus_ack),
      .i_rf_ready  (i_rf_ready),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_rf_rreq   (o_rf_rreq),
      .o_cnt_en    (cnt_en),
      .o_cnt_first (cnt_first),
      .o_cnt_last  ()
   );

   qerv_decode decode (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_alu_op   (alu_op),
      .o_op_b_imm (op_b_imm),
      .o_rd_write (rd_write)
   );

   qerv_immdec immdec (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt[XLEN-1:7]),
      .i_cnt_en   (cnt_en),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_imm      (imm)
   );

   qerv_alu alu (
      .clk         (clk),
      .i_cnt_en    (cnt_en),
      .i_cnt_first (cnt_first),
      .i_alu_op    (alu_op),
      .i_op_b_imm  (op_b_imm),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .i_imm       (imm),
      .o_rd        (alu_rd)
   );

   qerv_rf_if rf_if (
      .i_cnt_en   (cnt_en),
      .i_rd_write (rd_write),
      .i_rd_addr  (rd_addr),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_alu_rd   (alu_rd),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .o_wen0     (o_wen0),
      .o_wreg0    (o_wreg0),
      .o_wdata0   (o_wdata0),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   qerv_ctrl ctrl (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_cnt_en    (cnt_en),
      .i_cnt_first (cnt_first),
      .o_ibus_adr  (o_ibus_adr)
   );

endmodule

/* verilog/qerv_ctrl.sv */
`timescale 1ns/100ps

module qerv_ctrl (
   input  logic                      clk,
   input  logic                      i_rst,
   input  logic                      i_cnt_en,
   input  logic                      i_cnt_first,
   output logic [qerv_pkg::XLEN-1:0] o_ibus_adr
);
   import qerv_pkg::*;

   logic [XLEN-1:0]  pc_q;
   logic             carry_q;
   logic             carry_in;
   logic [NIB_W-1:0] addend;
   logic [NIB_W:0]   sum;

   // Increment enters on nibble 0, later nibbles only ripple the carry
   assign addend = i_cnt_first ? NIB_W'(PC_INC) : '0;
   assign carry_in = i_cnt_first ? 1'b0 : carry_q;
   assign sum = {1'b0, pc_q[NIB_W-1:0]} + {1'b0, addend} + {{NIB_W{1'b0}}, carry_in};

   // Full rotation over the run leaves the next address in place
   always_ff @(posedge clk) begin
      if (i_rst) begin
         pc_q <= RESET_PC;
      end else if (i_cnt_en) begin
         pc_q <= {sum[NIB_W-1:0], pc_q[XLEN-1:NIB_W]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= sum[NIB_W];
      end
   end

   assign o_ibus_adr = pc_q;

endmodule

/* verilog/qerv_rf_if.sv */
`timescale 1ns/100ps

module qerv_rf_if (
   input  logic                        i_cnt_en,
   input  logic                        i_rd_write,
   input  logic [qerv_pkg::REG_AW-1:0] i_rd_addr,
   input  logic [qerv_pkg::REG_AW-1:0] i_rs1_addr,
   input  logic [qerv_pkg::REG_AW-1:0] i_rs2_addr,
   input  logic [qerv_pkg::NIB_W-1:0]  i_alu_rd,
   input  logic [qerv_pkg::NIB_W-1:0]  i_rdata0,
   input  logic [qerv_pkg::NIB_W-1:0]  i_rdata1,
   output logic [qerv_pkg::REG_AW-1:0] o_rreg0,
   output logic [qerv_pkg::REG_AW-1:0] o_rreg1,
   output logic                        o_wen0,
   output logic [qerv_pkg::REG_AW-1:0] o_wreg0,
   output logic [qerv_pkg::NIB_W-1:0]  o_wdata0,
   output logic [qerv_pkg::NIB_W-1:0]  o_rs1,
   output logic [qerv_pkg::NIB_W-1:0]  o_rs2
);
   import qerv_pkg::*;

   logic rd_nonzero;

   // Read port 0 carries rs1, port 1 carries rs2
   assign o_rreg0 = i_rs1_addr;
   assign o_rreg1 = i_rs2_addr;
   assign o_rs1 = i_rdata0;
   assign o_rs2 = i_rdata1;

   // x0 is hardwired to zero so it never sees a write
   assign rd_nonzero = (i_rd_addr != REG_AW'(0));
   assign o_wen0 = i_cnt_en && i_rd_write && rd_nonzero;
   assign o_wreg0 = i_rd_addr;
   assign o_wdata0 = i_alu_rd;

endmodule

/* verilog/qerv_alu.sv */
`timescale 1ns/100ps

module qerv_alu (
   input  logic                       clk,
   input  logic                       i_cnt_en,
   input  logic                       i_cnt_first,
   input  qerv_pkg::alu_op_e          i_alu_op,
   input  logic                       i_op_b_imm,
   input  logic [qerv_pkg::NIB_W-1:0] i_rs1,
   input  logic [qerv_pkg::NIB_W-1:0] i_rs2,
   input  logic [qerv_pkg::NIB_W-1:0] i_imm,
   output logic [qerv_pkg::NIB_W-1:0] o_rd
);
   import qerv_pkg::*;

   logic [NIB_W-1:0] op_b;
   logic [NIB_W-1:0] add_b;
   logic             is_sub;
   logic             carry_q;
   logic             carry_in;
   logic [NIB_W:0]   sum;

   assign op_b = i_op_b_imm ? i_imm : i_rs2;
   assign is_sub = (i_alu_op == ALU_SUB);

   // Two's complement subtract, invert B and inject one on nibble 0
   assign add_b = is_sub ? ~op_b : op_b;
   assign carry_in = i_cnt_first ? is_sub : carry_q;
   assign sum = {1'b0, i_rs1} + {1'b0, add_b} + {{NIB_W{1'b0}}, carry_in};

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= sum[NIB_W];
      end
   end

   always_comb begin
      case (i_alu_op)
         ALU_ADD,
         ALU_SUB: o_rd = sum[NIB_W-1:0];
         ALU_AND: o_rd = i_rs1 & op_b;
         ALU_OR: o_rd = i_rs1 | op_b;
         ALU_XOR: o_rd = i_rs1 ^ op_b;
         default: o_rd = '0;
      endcase
   end

endmodule

/* verilog/qerv_immdec.sv */
`timescale 1ns/100ps

module qerv_immdec (
   input  logic                        clk,
   input  logic                        i_ibus_ack,
   input  logic [qerv_pkg::XLEN-1:7]   i_ibus_rdt,
   input  logic                        i_cnt_en,
   output logic [qerv_pkg::REG_AW-1:0] o_rd_addr,
   output logic [qerv_pkg::REG_AW-1:0] o_rs1_addr,
   output logic [qerv_pkg::REG_AW-1:0] o_rs2_addr,
   output logic [qerv_pkg::NIB_W-1:0]  o_imm
);
   import qerv_pkg::*;

   logic [IMM_W-1:0] imm_q;

   // Register fields stay put until the next fetch
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_rd_addr <= i_ibus_rdt[11:7];
         o_rs1_addr <= i_ibus_rdt[19:15];
         o_rs2_addr <= i_ibus_rdt[24:20];
      end
   end

   // I-type immediate, LSB nibble first
   // Top bit is never shifted out so it keeps feeding the sign
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_q <= i_ibus_rdt[31:20];
      end else if (i_cnt_en) begin
         imm_q <= {{NIB_W{imm_q[IMM_W-1]}}, imm_q[IMM_W-1:NIB_W]};
      end
   end

   assign o_imm = imm_q[NIB_W-1:0];

endmodule

/* verilog/qerv_decode.sv */
`timescale 1ns/100ps

module qerv_decode (
   input  logic                      clk,
   input  logic                      i_ibus_ack,
   input  logic [qerv_pkg::XLEN-1:0] i_ibus_rdt,
   output qerv_pkg::alu_op_e         o_alu_op,
   output logic                      o_op_b_imm,
   output logic                      o_rd_write
);
   import qerv_pkg::*;

   logic [6:0] opcode_q;
   logic [2:0] funct3_q;
   logic [6:0] funct7_q;
   logic       r_type;
   logic       i_type;
   logic       f7_base;
   logic       f7_sub;
   logic       f3_ok;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         opcode_q <= i_ibus_rdt[6:0];
         funct3_q <= i_ibus_rdt[14:12];
         funct7_q <= i_ibus_rdt[31:25];
      end
   end

   assign r_type = (opcode_q == OPC_OP);
   assign i_type = (opcode_q == OPC_OP_IMM);
   assign f7_base = (funct7_q == F7_BASE);
   assign f7_sub = (funct7_q == F7_SUB);

   // funct7 is immediate data for I-type and is ignored there
   always_comb begin
      o_alu_op = ALU_NONE;
      case (funct3_q)
         F3_ADD_SUB: begin
            if (i_type || (r_type && f7_base)) begin
               o_alu_op = ALU_ADD;
            end else if (r_type && f7_sub) begin
               o_alu_op = ALU_SUB;
            end
         end
         F3_XOR: if (i_type || (r_type && f7_base)) o_alu_op = ALU_XOR;
         F3_OR: if (i_type || (r_type && f7_base)) o_alu_op = ALU_OR;
         F3_AND: if (i_type || (r_type && f7_base)) o_alu_op = ALU_AND;
         default: o_alu_op = ALU_NONE;
      endcase
   end

   // Supported encodings write rd, everything else retires silently
   assign f3_ok = funct3_q inside {F3_ADD_SUB, F3_XOR, F3_OR, F3_AND};
   assign o_rd_write = f3_ok &&
      (i_type || (r_type && (f7_base || (f7_sub && funct3_q == F3_ADD_SUB))));
   assign o_op_b_imm = i_type;

   assert property (@(posedge clk) o_rd_write |-> o_alu_op != ALU_NONE);

endmodule

/* verilog/qerv_state.sv */
`timescale 1ns/100ps

module qerv_state (
   input  logic clk,
   input  logic i_rst,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_en,
   output logic o_cnt_first,
   output logic o_cnt_last
);
   import qerv_pkg::*;

   state_e           state_q;
   logic [CNT_W-1:0] cnt_q;
   logic             cyc_q;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q <= ST_FETCH;
         cyc_q <= 1'b0;
         cnt_q <= '0;
      end else begin
         case (state_q)
            ST_FETCH: begin
               // First cycle after reset only raises the request
               if (cyc_q && i_ibus_ack) begin
                  state_q <= ST_RREQ;
                  cyc_q <= 1'b0;
               end else begin
                  cyc_q <= 1'b1;
               end
            end
            ST_RREQ: begin
               state_q <= ST_WAIT;
            end
            ST_WAIT: begin
               if (i_rf_ready) begin
                  state_q <= ST_RUN;
               end
            end
            default: begin
               // Counter wraps back to zero on the last nibble
               cnt_q <= cnt_q + CNT_W'(1);
               if (o_cnt_last) begin
                  state_q <= ST_FETCH;
                  cyc_q <= 1'b1;
               end
            end
         endcase
      end
   end

   assign o_ibus_cyc = cyc_q;
   assign o_rf_rreq = (state_q == ST_RREQ);
   assign o_cnt_en = (state_q == ST_RUN);
   assign o_cnt_first = o_cnt_en && (cnt_q == '0);
   assign o_cnt_last = o_cnt_en && (cnt_q == CNT_W'(NIB_CNT - 1));

   assert property (@(posedge clk) disable iff (i_rst) !(o_rf_rreq && o_ibus_cyc));

   // Run window is one full word
   assert property (@(posedge clk) disable iff (i_rst)
      $rose(o_cnt_en) |-> ##NIB_CNT $fell(o_cnt_en));

endmodule

/* verilog/qerv_pkg.sv */
package qerv_pkg;

   // Datapath geometry
   localparam int NIB_W = 4;
   localparam int XLEN = 32;
   localparam int NIB_CNT = XLEN / NIB_W;
   localparam int CNT_W = $clog2(NIB_CNT);
   localparam int REG_AW = 5;
   localparam int IMM_W = 12;

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
   // Byte distance between instructions
   localparam int PC_INC = 4;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NONE
   } alu_op_e;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_RREQ,
      ST_WAIT,
      ST_RUN
   } state_e;

   // Major opcodes handled by decode
   typedef enum logic [6:0] {
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011
   } opcode_e;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage
